// ==== hw/ks_pkg.sv ====
package ks_pkg;

        typedef logic [6:0] midi_t;             // note number or velocity
        typedef logic signed [23:0] sample_t;
        typedef logic [9:0] delay_len_t;        // string length in steps
        typedef logic [3:0] step_shift_t;       // log2 cycles per step
        typedef logic [6:0] seg_t;              // bit 0 is segment a
        typedef logic [7:0] decay_t;

        localparam int NOTES_PER_OCTAVE = 12;
        localparam int TOP_OCTAVE = 10;         // half length here
        localparam int FULL_RATE_OCTAVE = 9;
        localparam int LINE_DEPTH = 1024;

        localparam sample_t NOISE_SEED = 24'h9e3779;

        // C up to B
        localparam delay_len_t BASE_DELAY [NOTES_PER_OCTAVE] = '{
                10'd734,
                10'd693,
                10'd654,
                10'd617,
                10'd582,
                10'd550,
                10'd519,
                10'd490,
                10'd462,
                10'd436,
                10'd412,
                10'd389
        };

        localparam seg_t SEG_C = 7'b0111001;
        localparam seg_t SEG_D = 7'b1011110;    // lower case d
        localparam seg_t SEG_E = 7'b1111001;
        localparam seg_t SEG_F = 7'b1110001;
        localparam seg_t SEG_G = 7'b1111101;
        localparam seg_t SEG_A = 7'b1110111;
        localparam seg_t SEG_B = 7'b1111100;    // lower case b, also the flat sign
        localparam seg_t SEG_BLANK = 7'b0000000;

endpackage

// ==== hw/note_decoder.sv ====
`timescale 1ns/1ps

module note_decoder
        import ks_pkg::*;
(
        input  logic        a_clk,
        input  logic        reset_n,
        input  logic        note_on,
        input  midi_t       note_number,
        output logic        retune,
        output delay_len_t  delay_len,
        output step_shift_t step_shift,
        output seg_t        hex0,
        output seg_t        hex1
);

        logic [3:0] pitch_class;
        logic [3:0] octave;
        delay_len_t table_len;
        step_shift_t oct_shift;
        seg_t letter_seg;
        logic is_flat;

        always_comb
        begin
                pitch_class = 4'(note_number % NOTES_PER_OCTAVE);
                octave = 4'(note_number / NOTES_PER_OCTAVE);

                table_len = BASE_DELAY[pitch_class];
                if (octave == TOP_OCTAVE)
                        table_len = table_len >> 1;     // top octave, half string

                if (octave >= FULL_RATE_OCTAVE)
                        oct_shift = '0;
                else
                        oct_shift = step_shift_t'(FULL_RATE_OCTAVE - octave);
        end

        // flats show the letter above, plus b on hex1
        always_comb
        begin
                is_flat = 1'b0;
                case (pitch_class)
                        4'd0: letter_seg = SEG_C;
                        4'd1:
                        begin
                                letter_seg = SEG_D;
                                is_flat = 1'b1;
                        end
                        4'd2: letter_seg = SEG_D;
                        4'd3:
                        begin
                                letter_seg = SEG_E;
                                is_flat = 1'b1;
                        end
                        4'd4: letter_seg = SEG_E;
                        4'd5: letter_seg = SEG_F;
                        4'd6:
                        begin
                                letter_seg = SEG_G;
                                is_flat = 1'b1;
                        end
                        4'd7: letter_seg = SEG_G;
                        4'd8:
                        begin
                                letter_seg = SEG_A;
                                is_flat = 1'b1;
                        end
                        4'd9: letter_seg = SEG_A;
                        4'd10:
                        begin
                                letter_seg = SEG_B;
                                is_flat = 1'b1;
                        end
                        4'd11: letter_seg = SEG_B;
                        default: letter_seg = SEG_BLANK;
                endcase
        end

        always_ff @(posedge a_clk)
        begin
                if (reset_n)
                begin
                        retune <= 1'b0;
                        delay_len <= BASE_DELAY[0];
                        step_shift <= '0;
                        hex0 <= SEG_BLANK;
                        hex1 <= SEG_BLANK;
                end
                else
                begin
                        retune <= note_on;
                        if (note_on)
                        begin
                                delay_len <= table_len;
                                step_shift <= oct_shift;
                                hex0 <= letter_seg;
                                hex1 <= is_flat ? SEG_B : SEG_BLANK;
                        end
                end
        end

endmodule

// ==== hw/noise_source.sv ====
`timescale 1ns/1ps

module noise_source
        import ks_pkg::*;
(
        input  logic    a_clk,
        input  logic    reset_n,
        output sample_t noise
);

        logic feedback;

        // taps 24, 23, 22, 17 give the maximal sequence
        assign feedback = noise[23] ^ noise[22] ^ noise[21] ^ noise[16];

        always_ff @(posedge a_clk)
        begin
                if (reset_n)
                        noise <= NOISE_SEED;            // any nonzero value
                else
                        noise <= {noise[22:0], feedback};
        end

endmodule

// ==== hw/string_voice.sv ====
`timescale 1ns/1ps

module string_voice
        import ks_pkg::*;
(
        input  logic        a_clk,
        input  logic        reset_n,
        input  logic        retune,
        input  delay_len_t  delay_len,
        input  step_shift_t step_shift,
        input  midi_t       velocity,
        input  sample_t     noise,
        input  decay_t      decay,
        input  logic        note_off,
        output sample_t     sample_out,
        output logic        sample_valid
);

        sample_t line_mem [LINE_DEPTH];
        logic [$clog2(LINE_DEPTH)-1:0] wr_ptr;
        logic [$clog2(LINE_DEPTH)-1:0] rd_ptr;

        logic [9:0] step_cnt;           // one bit past the 512 cycle step
        logic [9:0] cnt_inc;
        logic [9:0] step_mask;
        step_shift_t shift_r;
        step_shift_t act_shift;
        logic step;

        delay_len_t len_r;
        delay_len_t burst_cnt;
        delay_len_t burst_left;
        logic in_burst;

        midi_t vel_d;
        midi_t vel_r;
        midi_t act_vel;
        logic muted;

        sample_t tap;
        sample_t prev_tap;              // y[n-L-1]
        logic signed [31:0] burst_prod;
        logic signed [24:0] pair_sum;
        logic signed [33:0] filt_prod;
        sample_t next_y;

        always_comb
        begin
                // retune clears the counter, its own cycle counts as the first
                cnt_inc = (retune ? 10'd0 : step_cnt) + 10'd1;
                act_shift = retune ? step_shift : shift_r;
                step_mask = (10'd1 << act_shift) - 10'd1;
                step = (cnt_inc & step_mask) == 10'd0;

                burst_left = retune ? delay_len : burst_cnt;
                in_burst = burst_left != '0;
                act_vel = retune ? vel_d : vel_r;

                rd_ptr = wr_ptr - len_r;        // y[n-L]
                tap = line_mem[rd_ptr];

                burst_prod = 32'(noise >>> 7) * 32'($signed({1'b0, act_vel}));
                pair_sum = 25'(tap) + 25'(prev_tap);
                filt_prod = 34'(pair_sum) * 34'($signed({1'b0, decay}));

                if (muted && !retune)
                        next_y = '0;
                else if (in_burst)
                        next_y = sample_t'(burst_prod);
                else
                        next_y = sample_t'(filt_prod >>> 9);    // average and decay
        end

        always_ff @(posedge a_clk)
        begin
                if (reset_n)
                begin
                        step_cnt <= '0;
                        shift_r <= '0;
                        len_r <= BASE_DELAY[0];
                        burst_cnt <= '0;
                        wr_ptr <= '0;
                        prev_tap <= '0;
                        muted <= 1'b1;                  // silent until the first note
                        sample_out <= '0;
                        sample_valid <= 1'b0;
                end
                else
                begin
                        step_cnt <= cnt_inc;
                        sample_valid <= step;
                        muted <= note_off || (muted && !retune);

                        if (step && in_burst)
                                burst_cnt <= burst_left - delay_len_t'(1);
                        else
                                burst_cnt <= burst_left;

                        if (retune)
                        begin
                                shift_r <= step_shift;
                                len_r <= delay_len;
                        end

                        if (retune)
                                prev_tap <= '0;
                        else if (step && !in_burst)
                                prev_tap <= tap;

                        if (step)
                        begin
                                wr_ptr <= wr_ptr + 1'b1;
                                sample_out <= next_y;
                        end
                end
        end

        // velocity lines up with the one cycle decoder latency
        always_ff @(posedge a_clk)
        begin
                vel_d <= velocity;
                if (retune)
                        vel_r <= vel_d;
        end

        always_ff @(posedge a_clk)
        begin
                if (step)
                        line_mem[wr_ptr] <= next_y;
        end

endmodule

// ==== hw/ks_synth_top.sv ====
`timescale 1ns/1ps

module ks_synth_top
        import ks_pkg::*;
(
        input  logic    a_clk,
        input  logic    reset_n,
        input  logic    note_on,
        input  logic    note_off,
        input  midi_t   note_number,
        input  midi_t   velocity,
        input  decay_t  decay,
        output seg_t    hex0,
        output seg_t    hex1,
        output sample_t sample_out,
        output logic    sample_valid
);

        logic retune;
        delay_len_t delay_len;
        step_shift_t step_shift;
        sample_t noise;

        note_decoder note_decoder_i (
                .a_clk       (a_clk),
                .reset_n     (reset_n),
                .note_on     (note_on),
                .note_number (note_number),
                .retune      (retune),
                .delay_len   (delay_len),
                .step_shift  (step_shift),
                .hex0        (hex0),
                .hex1        (hex1)
        );

        noise_source noise_source_i (
                .a_clk   (a_clk),
                .reset_n (reset_n),
                .noise   (noise)
        );

        string_voice string_voice_i (
                .a_clk        (a_clk),
                .reset_n      (reset_n),
                .retune       (retune),
                .delay_len    (delay_len),
                .step_shift   (step_shift),
                .velocity     (velocity),
                .noise        (noise),
                .decay        (decay),
                .note_off     (note_off),
                .sample_out   (sample_out),
                .sample_valid (sample_valid)
        );

endmodule

// ==== dv/ks_tests.svh ====
function automatic int exp_len(input int note);
        int len;
        len = int'(BASE_DELAY[note % NOTES_PER_OCTAVE]);
        if (note / NOTES_PER_OCTAVE == TOP_OCTAVE)
                len = len / 2;                  // top octave, half string
        return len;
endfunction

function automatic int exp_shift(input int note);
        int oct;
        oct = note / NOTES_PER_OCTAVE;
        return (oct >= FULL_RATE_OCTAVE) ? 0 : FULL_RATE_OCTAVE - oct;
endfunction

function automatic seg_t exp_letter(input int pc);
        case (pc)
                0: return SEG_C;
                1, 2: return SEG_D;
                3, 4: return SEG_E;
                5: return SEG_F;
                6, 7: return SEG_G;
                8, 9: return SEG_A;
                default: return SEG_B;
        endcase
endfunction

function automatic bit exp_flat(input int pc);
        return pc == 1 || pc == 3 || pc == 6 || pc == 8 || pc == 10;
endfunction

task automatic play_note(input int note, input int vel);
        @(posedge a_clk);
        note_on <= 1'b1;
        note_number <= midi_t'(note);
        velocity <= midi_t'(vel);
        note_cyc = cyc + 1;
        rec_from = cyc + 3;             // skip a step left over from the old note
        samp_q.delete();
        stamp_q.delete();
        @(posedge a_clk);
        note_on <= 1'b0;
endtask

task automatic pulse_note_off();
        @(posedge a_clk);
        note_off <= 1'b1;
        rec_from = cyc + 3;             // a step in the off cycle is still live
        samp_q.delete();
        stamp_q.delete();
        @(posedge a_clk);
        note_off <= 1'b0;
endtask

task automatic wait_samples(input int n, input int limit, output bit ok);
        int waited;
        waited = 0;
        while (samp_q.size() < n && waited < limit)
        begin
                @(posedge a_clk);
                waited++;
        end
        ok = samp_q.size() >= n;
        check_true(ok, $sformatf("timed out after %0d cycles waiting for %0d samples",
                                 limit, n));
endtask

task automatic test_reset_state();
        @(negedge a_clk);
        check_val("hex0", SEG_BLANK, hex0);
        check_val("hex1", SEG_BLANK, hex1);
        check_val("sample_out", 0, sample_out);
        @(posedge a_clk);
        samp_q.delete();
        stamp_q.delete();
        rec_from = cyc + 1;
        repeat (2000) @(posedge a_clk);
        check_true(samp_q.size() > 0, "no samples arrived after reset");
        foreach (samp_q[i])
                check_val("sample_out", 0, samp_q[i]);
endtask

task automatic test_display();
        int pc;
        int oct;
        for (pc = 0; pc < NOTES_PER_OCTAVE; pc++)
        begin
                oct = rand_bits(4) % 11;
                if (oct * NOTES_PER_OCTAVE + pc > 127)
                        oct = 9;
                play_note(oct * NOTES_PER_OCTAVE + pc, rand_bits(7));
                @(negedge a_clk);
                check_val("hex0", exp_letter(pc), hex0);
                check_val("hex1", exp_flat(pc) ? SEG_B : SEG_BLANK, hex1);
        end
endtask

task automatic test_step_rate();
        int oct;
        int note;
        int gap;
        int i;
        bit ok;
        for (oct = 0; oct <= TOP_OCTAVE; oct++)
        begin
                note = oct * NOTES_PER_OCTAVE + rand_bits(3);   // stays below 128
                gap = 1 << exp_shift(note);
                play_note(note, 64);
                wait_samples(4, 4 * gap + 20, ok);
                if (ok)
                begin
                        check_val("sample_valid gap", gap, stamp_q[0] - note_cyc - 1);
                        for (i = 1; i < 4; i++)
                                check_val("sample_valid gap", gap, stamp_q[i] - stamp_q[i-1]);
                end
        end
endtask

task automatic test_string();
        int notes [4];
        int k;
        int n;
        int len;
        bit ok;
        bit any_burst;
        longint sum;
        sample_t y_exp;
        notes[0] = 60;
        notes[1] = 120;
        notes[2] = 108 + rand_bits(3);
        notes[3] = 96 + rand_bits(4) % 12;
        for (k = 0; k < 4; k++)
        begin
                len = exp_len(notes[k]);
                play_note(notes[k], rand_velocity());
                wait_samples(2 * len + 4, (2 * len + 4) * (1 << exp_shift(notes[k])) + 50, ok);
                if (ok)
                begin
                        any_burst = 1'b0;
                        for (n = 0; n < len; n++)
                                if (samp_q[n] != 0)
                                        any_burst = 1'b1;
                        check_true(any_burst, $sformatf("burst of note %0d is all zero",
                                                        notes[k]));
                        for (n = len; n < 2 * len + 4; n++)
                        begin
                                sum = longint'(samp_q[n-len]);
                                if (n > len)
                                        sum = sum + longint'(samp_q[n-len-1]);
                                y_exp = sample_t'((sum * longint'(decay)) >>> 9);
                                check_val($sformatf("sample_out[%0d]", n), y_exp, samp_q[n]);
                        end
                end
        end
endtask

task automatic test_velocity_zero();
        int note;
        int len;
        int n;
        bit ok;
        note = 108 + rand_bits(4);              // full rate octaves
        len = exp_len(note);
        play_note(note, 0);
        wait_samples(3 * len, 3 * len + 50, ok);
        if (ok)
                for (n = 0; n < 3 * len; n++)
                        check_val($sformatf("sample_out[%0d]", n), 0, samp_q[n]);
endtask

task automatic test_note_off();
        int note;
        int len;
        int n;
        bit ok;
        bit any_burst;
        note = 108 + rand_bits(4);
        len = exp_len(note);
        play_note(note, rand_velocity());
        wait_samples(len + 16, len + 80, ok);
        pulse_note_off();
        wait_samples(2 * len, 2 * len + 50, ok);
        if (ok)
                for (n = 0; n < 2 * len; n++)
                        check_val($sformatf("sample_out[%0d]", n), 0, samp_q[n]);
        play_note(note, rand_velocity());
        wait_samples(len, len + 50, ok);
        if (ok)
        begin
                any_burst = 1'b0;
                foreach (samp_q[i])
                        if (samp_q[i] != 0)
                                any_burst = 1'b1;
                check_true(any_burst, "no burst after a new note following note_off");
        end
endtask

// ==== dv/ks_synth_tb.sv ====
`timescale 1ns/1ps

module ks_synth_tb
        import ks_pkg::*;
();

        logic a_clk;
        logic reset_n;
        logic note_on;
        logic note_off;
        midi_t note_number;
        midi_t velocity;
        decay_t decay;
        seg_t hex0;
        seg_t hex1;
        sample_t sample_out;
        logic sample_valid;

        int cyc = 0;                    // counted on falling edges
        int rec_from = 0;
        int note_cyc = 0;               // stamp of the note_on cycle
        sample_t samp_q [$];
        int stamp_q [$];
        int value_errs = 0;
        int other_errs = 0;
        logic [15:0] lfsr_q = 16'd26273;

        ks_synth_top dut_i (
                .a_clk        (a_clk),
                .reset_n      (reset_n),
                .note_on      (note_on),
                .note_off     (note_off),
                .note_number  (note_number),
                .velocity     (velocity),
                .decay        (decay),
                .hex0         (hex0),
                .hex1         (hex1),
                .sample_out   (sample_out),
                .sample_valid (sample_valid)
        );

        initial
        begin
                a_clk = 1'b0;
                forever #5 a_clk = ~a_clk;
        end

        // sample monitor, outputs are stable at the falling edge
        always @(negedge a_clk)
        begin
                cyc = cyc + 1;
                if (sample_valid && cyc >= rec_from)
                begin
                        samp_q.push_back(sample_out);
                        stamp_q.push_back(cyc);
                end
        end

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        function automatic int rand_bits(input int n);
                int v;
                int i;
                v = 0;
                for (i = 0; i < n; i++)
                begin
                        lfsr_q = lfsr_next(lfsr_q);
                        v = (v << 1) | int'(lfsr_q[0]);
                end
                return v;
        endfunction

        function automatic int rand_velocity();
                int v;
                v = rand_bits(7);
                if (v == 0)
                        v = 1;
                return v;
        endfunction

        task automatic check_val(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
                assert (act === exp)
                else
                begin
                        value_errs++;
                        $display("ERR %s expected %h actual %h at cycle %0d", sig, exp, act, cyc);
                end
        endtask

        task automatic check_true(input bit cond, input string what);
                assert (cond)
                else
                begin
                        other_errs++;
                        $display("%s (cycle %0d)", what, cyc);
                end
        endtask

        `include "ks_tests.svh"

        initial
        begin
                reset_n = 1'b1;
                note_on = 1'b0;
                note_off = 1'b0;
                note_number = '0;
                velocity = '0;
                decay = 8'd255;
                repeat (4) @(posedge a_clk);
                reset_n <= 1'b0;

                test_reset_state();
                test_display();
                test_step_rate();
                test_string();
                test_velocity_zero();
                test_note_off();

                $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
                if (value_errs == 0 && other_errs == 0)
                        $display("Finished with no errors");
                else
                        $display("Finished with errors");
                $finish;
        end

endmodule

// ==== ks_synth.f ====
+incdir+dv
hw/ks_pkg.sv
hw/note_decoder.sv
hw/noise_source.sv
hw/string_voice.sv
hw/ks_synth_top.sv
dv/ks_synth_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the ks_synth testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
        --top-module ks_synth_tb -f ks_synth.f -o ks_synth_sim \
        && ./obj_dir/ks_synth_sim > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "Finished with no errors" sim.log && exit 0 || exit 1
